// File: init_fsm.sv
// Init FSM: runs the zero sweep once after reset, then raises ready for the user port
module init_fsm
(
   input  logic                       CLK,
   input  logic                       rst_n,
   input  logic                       sweep_last, // Counter on top word
   output logic                       sweep_en,   // Step the counter
   output tcm_ctrl_pkg::ctrl_status_t status
);

   tcm_ctrl_pkg::init_state_e state_q; // Current state
   tcm_ctrl_pkg::init_state_e state_d; // Next state

   // Next state
   always_comb
   begin
      state_d = state_q;
      unique case (state_q)
         tcm_ctrl_pkg::INIT_IDLE:
         begin
            state_d = tcm_ctrl_pkg::INIT_CLEAR; // First edge out of reset
         end
         tcm_ctrl_pkg::INIT_CLEAR:
         begin
            if (sweep_last)
            begin
               state_d = tcm_ctrl_pkg::INIT_READY; // Top word written this edge
            end
         end
         tcm_ctrl_pkg::INIT_READY:
         begin
            state_d = tcm_ctrl_pkg::INIT_READY; // Sticky until reset
         end
         default:
         begin
            state_d = tcm_ctrl_pkg::INIT_IDLE;
         end
      endcase
   end

   always_ff @(posedge CLK or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q <= tcm_ctrl_pkg::INIT_IDLE;
      end
      else
      begin
         state_q <= state_d;
      end
   end

   // Outputs decoded from state only
   always_comb
   begin
      unique case (state_q)
         tcm_ctrl_pkg::INIT_CLEAR: status = tcm_ctrl_pkg::STATUS_CLEAR;
         tcm_ctrl_pkg::INIT_READY: status = tcm_ctrl_pkg::STATUS_READY;
         default:                  status = tcm_ctrl_pkg::STATUS_IDLE;
      endcase
   end

   assign sweep_en = status.clearing; // One word per clearing cycle

endmodule

// File: mem_pkg.sv
// Data-path types for the TCM: word, byte enables, uncertain pattern, request struct
package mem_pkg;

   // Word geometry, fixed by the CPU load/store path
   localparam int DATA_W     = 64;
   localparam int DATA_BYTES = DATA_W / 8; // Byte lanes per word

   // One memory word
   typedef logic [DATA_W-1:0] data_t;

   // Byte write enable, bit i covers din[8*i +: 8]
   typedef logic [DATA_BYTES-1:0] be_t;

   // Pattern the SRAM model shows for one cycle after a write,
   // as the real cell output is not valid then
   localparam data_t UNCERTAIN_VAL = {(DATA_W / 2){2'b01}};

   // Request into the SRAM, 73 bits
   // Address is carried beside it since its width follows AW
   typedef struct packed {
      logic  re;  // Read strobe
      be_t   we;  // Per-byte write strobes
      data_t din; // Write data
   } mem_req_t;

   // Nothing requested
   localparam mem_req_t MEM_REQ_IDLE = '{
      re:  1'b0,
      we:  '0,
      din: '0
   };

   // Zero-fill write used by the init sweep, all lanes on
   localparam mem_req_t MEM_REQ_CLEAR = '{
      re:  1'b0,
      we:  '1,
      din: '0
   };

endpackage

// File: sim.f
mem_pkg.sv
tcm_ctrl_pkg.sv
sram_sp_be.sv
sweep_counter.sv
init_fsm.sv
tcm_port_mux.sv
tcm_top.sv
tcm_checker.sv
tcm_tb.sv

// File: sram_sp_be.sv
// Single-port SRAM model with byte writes, registered read and uncertain output after writes
module sram_sp_be
#(
   parameter int AW = 6 // Word address width
)
(
   input  logic               CLK,
   input  logic               rst_n,
   input  mem_pkg::mem_req_t  req,  // re, we, din
   input  logic [AW-1:0]      addr, // Word address
   output mem_pkg::data_t     dout
);

   localparam int DEPTH = 1 << AW; // Words in the array

   mem_pkg::data_t mem [DEPTH]; // Storage array
   mem_pkg::data_t rd_q;        // Read data register
   logic           wr_any;      // Some lane written this cycle
   logic           wr_q;        // Write happened on last edge

   assign wr_any = |req.we;

   // Read register, loaded only on re
   // Same-edge write lands after, so the old word comes back
   always_ff @(posedge CLK)
   begin
      if (req.re)
      begin
         rd_q <= mem[addr];
      end
   end

   // Byte-lane write
   always_ff @(posedge CLK)
   begin
      for (int b = 0; b < mem_pkg::DATA_BYTES; b++)
      begin
         if (req.we[b])
         begin
            mem[addr][b*8 +: 8] <= req.din[b*8 +: 8]; // One lane
         end
      end
   end

   // Write flag for the output mux
   always_ff @(posedge CLK or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_q <= 1'b0;
      end
      else
      begin
         wr_q <= wr_any;
      end
   end

   // Real cell drives junk in the cycle after a write,
   // model it with a fixed pattern so the CPU never relies on it
   always_comb
   begin
      if (wr_q)
      begin
         dout = mem_pkg::UNCERTAIN_VAL;
      end
      else
      begin
         dout = rd_q; // Held read data
      end
   end

endmodule

// File: sweep_counter.sv
// Word address counter for the zero-fill sweep; steps while enabled and flags the last word
module sweep_counter
#(
   parameter int AW = 6 // Word address width
)
(
   input  logic          CLK,
   input  logic          rst_n,
   input  logic          sweep_en,   // Advance one word
   output logic [AW-1:0] sweep_addr, // Word being cleared
   output logic          sweep_last  // Current word is the top one
);

   logic [AW-1:0] cnt_q; // Current word
   logic [AW-1:0] cnt_d; // Next word

   // Natural wrap back to 0 after the top word
   always_comb
   begin
      if (sweep_en)
      begin
         cnt_d = cnt_q + 1'b1;
      end
      else
      begin
         cnt_d = cnt_q; // Hold
      end
   end

   always_ff @(posedge CLK or negedge rst_n)
   begin
      if (!rst_n)
      begin
         cnt_q <= '0; // Sweep starts at word 0
      end
      else
      begin
         cnt_q <= cnt_d;
      end
   end

   assign sweep_addr = cnt_q;
   assign sweep_last = &cnt_q; // All ones, last word

endmodule

// File: tcm_checker.sv
// Concurrent checks on the TCM control timing, bound into tcm_top by the bind at the end
module tcm_checker
(
   input logic              CLK,
   input logic              rst_n,
   input logic              ready,
   input logic              sweep_en,
   input mem_pkg::mem_req_t sram_req
);
   timeunit 1ns;
   timeprecision 100ps;

   // Async reset clears the FSM, so ready is low at every edge in reset
   ready_low_in_reset: assert property (@(posedge CLK) !rst_n |-> !ready)
      else $error("ready high while reset is asserted");

   // Handover is one way until the next reset
   ready_sticky: assert property (@(posedge CLK) disable iff (!rst_n) ready |=> ready)
      else $error("ready fell without a reset");

   // Outside the sweep and before ready, the mux must send no write
   no_early_user_write: assert property (@(posedge CLK) disable iff (!rst_n)
      (!ready && !sweep_en) |-> (sram_req.we == '0))
      else $error("SRAM write seen before ready outside the sweep");

   ready_sweep_exclusive: assert property (@(posedge CLK) !(sweep_en && ready))
      else $error("sweep_en and ready high together");

endmodule

bind tcm_top tcm_checker u_checker (
   .CLK      (CLK),
   .rst_n    (rst_n),
   .ready    (ready),
   .sweep_en (sweep_en),
   .sram_req (sram_req)
);

// File: tcm_ctrl_pkg.sv
// Control types for the TCM: init state encoding and the status bits seen by the mux and top
package tcm_ctrl_pkg;

   // Init sequence states
   typedef enum logic [1:0] {
      INIT_IDLE  = 2'd0, // Just out of reset
      INIT_CLEAR = 2'd1, // Zero sweep running
      INIT_READY = 2'd2  // SRAM handed to user port
   } init_state_e;

   // Status from the init FSM
   typedef struct packed {
      logic clearing; // Sweep owns the SRAM
      logic ready;    // User port owns the SRAM
   } ctrl_status_t;

   // Neither owner, the state right after reset
   localparam ctrl_status_t STATUS_IDLE = '{
      clearing: 1'b0,
      ready:    1'b0
   };

   // Sweep in progress
   localparam ctrl_status_t STATUS_CLEAR = '{
      clearing: 1'b1,
      ready:    1'b0
   };

   // Handover done, held until reset
   localparam ctrl_status_t STATUS_READY = '{
      clearing: 1'b0,
      ready:    1'b1
   };

endpackage

// File: tcm_port_mux.sv
// SRAM port mux: zero-fill writes during the sweep, user requests once ready, idle otherwise
module tcm_port_mux
#(
   parameter int AW = 6 // Word address width
)
(
   input  tcm_ctrl_pkg::ctrl_status_t status,
   input  logic [AW-1:0]              sweep_addr, // Word to clear
   input  mem_pkg::mem_req_t          user_req,
   input  logic [AW-1:0]              user_addr,
   output mem_pkg::mem_req_t          sram_req,
   output logic [AW-1:0]              sram_addr
);

   // Sweep has priority; the FSM never raises both
   always_comb
   begin
      if (status.clearing)
      begin
         sram_req  = mem_pkg::MEM_REQ_CLEAR; // All lanes, zero data
         sram_addr = sweep_addr;
      end
      else if (status.ready)
      begin
         sram_req  = user_req; // Straight through
         sram_addr = user_addr;
      end
      else
      begin
         // Before ready, user strobes are dropped here
         sram_req  = mem_pkg::MEM_REQ_IDLE;
         sram_addr = '0;
      end
   end

endmodule

// File: tcm_tb.sv
// Simulation top that drives tcm_top with LFSR stimulus and checks dout against a reference model
module tcm_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int AW           = 6;
   localparam int DEPTH        = 1 << AW;
   localparam int INIT_TIMEOUT = DEPTH + 4; // Sweep plus a little slack
   localparam int MIX_CYCLES   = 2000;

   logic              CLK;
   logic              rst_n;
   mem_pkg::mem_req_t user_req;
   logic [AW-1:0]     addr;
   mem_pkg::data_t    dout;
   logic              ready;

   mem_pkg::data_t    model_mem [DEPTH]; // Expected array contents
   mem_pkg::data_t    model_rd;          // Expected read register
   logic              model_rd_ok;       // Read register loaded at least once
   logic              model_wr;          // Write on the last edge
   mem_pkg::mem_req_t pend_req;          // Driven now and captured on the next edge
   logic [AW-1:0]     pend_addr;
   logic [31:0]       lfsr_q;
   logic              init_ok;
   int                err_count;
   int                check_count;
   int                test_count;
   int                test_fails;
   int                test_err_base;

   tcm_top #(.AW(AW)) uut (
      .CLK      (CLK),
      .rst_n    (rst_n),
      .user_req (user_req),
      .addr     (addr),
      .dout     (dout),
      .ready    (ready)
   );

   always
   begin
      #4 CLK = ~CLK; // 8 ns period
   end

   // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'h8020_0003;
      return s >> 1;
   endfunction

   // One LFSR step per bit taken
   function automatic logic [63:0] take_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v[i]   = lfsr_q[0];
         lfsr_q = lfsr_step(lfsr_q);
      end
      return v;
   endfunction

   function automatic logic [AW-1:0] random_addr();
      logic [63:0] v;
      v = take_bits(AW);
      return v[AW-1:0];
   endfunction

   function automatic mem_pkg::mem_req_t make_req(input logic re, input mem_pkg::be_t we,
                                                  input mem_pkg::data_t din);
      mem_pkg::mem_req_t r;
      r.re  = re;
      r.we  = we;
      r.din = din;
      return r;
   endfunction

   // About half the cycles carry a write
   function automatic mem_pkg::mem_req_t random_req();
      logic [63:0] v;
      logic        re;
      logic        wr_on;
      v     = take_bits(1);
      re    = v[0];
      v     = take_bits(1);
      wr_on = v[0];
      v     = take_bits(8);
      return make_req(re, wr_on ? v[7:0] : 8'h00, take_bits(64));
   endfunction

   // Same-edge read sees the word before the write lands
   task automatic apply_model(input mem_pkg::mem_req_t r, input logic [AW-1:0] a);
      mem_pkg::data_t w;
      w = model_mem[a];
      if (r.re)
      begin
         model_rd    = w;
         model_rd_ok = 1'b1;
      end
      for (int b = 0; b < mem_pkg::DATA_BYTES; b++)
         if (r.we[b])
            w[b*8 +: 8] = r.din[b*8 +: 8]; // Enabled lane only
      model_mem[a] = w;
      model_wr     = |r.we;
   endtask

   task automatic check_value(input string name, input mem_pkg::data_t got,
                              input mem_pkg::data_t exp);
      check_count++;
      assert (got === exp)
      else
      begin
         $display("MISMATCH %s: expected 0x%h, got 0x%h at %0t", name, exp, got, $time);
         err_count++;
      end
   endtask

   task automatic compare_dout();
      if (model_wr)
         check_value("dout", dout, mem_pkg::UNCERTAIN_VAL);
      else if (model_rd_ok)
         check_value("dout", dout, model_rd); // Only once the register was loaded
   endtask

   // Drive on the edge and check mid-cycle what the previous request produced
   task automatic run_cycle(input mem_pkg::mem_req_t r, input logic [AW-1:0] a);
      @(posedge CLK);
      user_req <= r;
      addr     <= a;
      @(negedge CLK);
      apply_model(pend_req, pend_addr);
      compare_dout();
      check_count++;
      assert (ready === 1'b1)
      else
      begin
         $display("ERROR: ready went low after initialization at %0t", $time);
         err_count++;
      end
      pend_req  = r;
      pend_addr = a;
   endtask

   task automatic finish_test(input string name);
      int errs;
      errs = err_count - test_err_base;
      test_count++;
      if (errs != 0)
         test_fails++;
      $display("test %s %s, %0d errors", name, (errs == 0) ? "ok" : "FAIL", errs);
      test_err_base = err_count;
   endtask

   // Random requests during the sweep must be dropped
   task automatic init_test(output logic seen);
      mem_pkg::mem_req_t r;
      logic [AW-1:0]     a;
      int                cyc;
      seen = 1'b0;
      cyc  = 0;
      repeat (8) @(posedge CLK);
      rst_n    <= 1'b1;
      user_req <= make_req(1'b1, 8'hff, take_bits(64)); // Write in the FSM idle cycle
      addr     <= random_addr();
      while (!seen && cyc < INIT_TIMEOUT)
      begin
         @(posedge CLK);
         r = random_req();
         a = random_addr();
         user_req <= r;
         addr     <= a;
         @(negedge CLK);
         if (ready)
         begin
            seen      = 1'b1;
            pend_req  = r; // Captured once ready is high
            pend_addr = a;
         end
         cyc++;
      end
      check_count++;
      assert (seen)
      else
      begin
         $display("ERROR: ready did not rise within %0d cycles after reset", INIT_TIMEOUT);
         err_count++;
      end
      if (seen)
      begin
         model_wr = 1'b1; // Last sweep write just landed
         check_value("dout", dout, mem_pkg::UNCERTAIN_VAL);
      end
      finish_test("init");
   endtask

   task automatic zero_fill_test();
      for (int a = 0; a < DEPTH; a++)
         run_cycle(make_req(1'b1, '0, '0), a[AW-1:0]);
      run_cycle(mem_pkg::MEM_REQ_IDLE, '0); // Last read result
      finish_test("zero_fill");
   endtask

   task automatic byte_lane_test();
      logic [AW-1:0]  a;
      logic [63:0]    v;
      mem_pkg::be_t   we;
      mem_pkg::data_t din;
      for (int i = 0; i < 48; i++)
      begin
         a   = random_addr();
         v   = take_bits(8);
         we  = (v[7:0] == 8'h00) ? 8'h01 : v[7:0]; // At least one lane
         din = take_bits(64);
         run_cycle(make_req(1'b0, we, din), a);
         run_cycle(make_req(1'b1, '0, '0), a);
      end
      run_cycle(mem_pkg::MEM_REQ_IDLE, '0);
      finish_test("byte_lane");
   endtask

   task automatic uncertain_test();
      logic [AW-1:0] a;
      logic [AW-1:0] b;
      for (int i = 0; i < 16; i++)
      begin
         a = random_addr();
         b = random_addr();
         run_cycle(make_req(1'b1, '0, '0), a);
         run_cycle(make_req(1'b0, 8'hff, take_bits(64)), b);
         run_cycle(mem_pkg::MEM_REQ_IDLE, '0);
         check_value("dout", dout, mem_pkg::UNCERTAIN_VAL); // Cycle after the write
         run_cycle(mem_pkg::MEM_REQ_IDLE, '0);
         check_value("dout", dout, model_rd); // Back to the read of a
      end
      finish_test("uncertain");
   endtask

   task automatic hold_rbw_test();
      logic [AW-1:0]  a;
      mem_pkg::data_t old_w;
      mem_pkg::data_t new_w;
      for (int i = 0; i < 16; i++)
      begin
         a = random_addr();
         run_cycle(make_req(1'b1, '0, '0), a);
         repeat (3) run_cycle(mem_pkg::MEM_REQ_IDLE, '0); // dout holds the read
         old_w = model_mem[a];
         new_w = take_bits(64);
         run_cycle(make_req(1'b1, 8'hff, new_w), a);
         run_cycle(mem_pkg::MEM_REQ_IDLE, '0);
         run_cycle(mem_pkg::MEM_REQ_IDLE, '0);
         check_value("dout", dout, old_w); // Old word from the shared edge
         run_cycle(make_req(1'b1, '0, '0), a);
         run_cycle(mem_pkg::MEM_REQ_IDLE, '0);
         check_value("dout", dout, new_w);
      end
      finish_test("hold_rbw");
   endtask

   task automatic mixed_test();
      mem_pkg::mem_req_t r;
      logic [AW-1:0]     a;
      for (int i = 0; i < MIX_CYCLES; i++)
      begin
         r = random_req();
         a = random_addr();
         run_cycle(r, a);
      end
      run_cycle(mem_pkg::MEM_REQ_IDLE, '0);
      finish_test("mixed");
   endtask

   task automatic end_run();
      $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
               test_count, test_fails, check_count, err_count);
      if (err_count == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   endtask

   initial
   begin
      CLK           = 1'b0;
      rst_n         = 1'b0;
      user_req      = mem_pkg::MEM_REQ_IDLE;
      addr          = '0;
      lfsr_q        = 32'd2; // Seed
      err_count     = 0;
      check_count   = 0;
      test_count    = 0;
      test_fails    = 0;
      test_err_base = 0;
      model_rd      = '0;
      model_rd_ok   = 1'b0;
      model_wr      = 1'b0;
      pend_req      = mem_pkg::MEM_REQ_IDLE;
      pend_addr     = '0;
      for (int w = 0; w < DEPTH; w++)
         model_mem[w] = '0; // State after the zero sweep
      init_test(init_ok);
      if (init_ok)
      begin
         zero_fill_test();
         byte_lane_test();
         uncertain_test();
         hold_rbw_test();
         mixed_test();
      end
      end_run();
   end

endmodule

// File: tcm_top.sv
// TCM top level: init FSM, sweep counter, port mux and SRAM; one-cycle read to dout
module tcm_top
#(
   parameter int AW = 6 // Word address width, 64 words by default
)
(
   input  logic              CLK,
   input  logic              rst_n,
   input  mem_pkg::mem_req_t user_req, // re, we, din from the core
   input  logic [AW-1:0]     addr,     // Word address from the core
   output mem_pkg::data_t    dout,
   output logic              ready     // Init done, user port live
);

   tcm_ctrl_pkg::ctrl_status_t status;     // FSM status
   logic                       sweep_en;   // FSM to counter
   logic                       sweep_last; // Counter to FSM
   logic [AW-1:0]              sweep_addr; // Counter to mux
   mem_pkg::mem_req_t          sram_req;   // Mux to SRAM
   logic [AW-1:0]              sram_addr;

   init_fsm u_init_fsm (
      .CLK        (CLK),
      .rst_n      (rst_n),
      .sweep_last (sweep_last),
      .sweep_en   (sweep_en),
      .status     (status)
   );

   sweep_counter #(.AW(AW)) u_sweep_counter (
      .CLK        (CLK),
      .rst_n      (rst_n),
      .sweep_en   (sweep_en),
      .sweep_addr (sweep_addr),
      .sweep_last (sweep_last)
   );

   tcm_port_mux #(.AW(AW)) u_port_mux (
      .status     (status),
      .sweep_addr (sweep_addr),
      .user_req   (user_req),
      .user_addr  (addr),
      .sram_req   (sram_req),
      .sram_addr  (sram_addr)
   );

   sram_sp_be #(.AW(AW)) u_sram (
      .CLK   (CLK),
      .rst_n (rst_n),
      .req   (sram_req),
      .addr  (sram_addr),
      .dout  (dout)
   );

   assign ready = status.ready;

endmodule
